// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= chan_proc_tb
FILELIST   ?= list.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= Verification passed
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== block_fifo.sv ====
`include "chan_config.svh"

module block_fifo (
	input  logic                  ADCCLK,
	input  logic                  rst,
	input  logic                  blk_start,  // writer asks for room
	input  logic [`WIN_BITS+1:0]  need,       // words in the coming block
	output logic                  space_ok,
	input  logic                  wr_en,
	input  chan_pkg::word_t       wr_word,
	input  logic                  blk_commit, // publish words written so far
	output chan_pkg::word_t       out_data,
	output logic                  out_valid,
	input  logic                  out_ready
);
	import chan_pkg::*;

	localparam int DEPTH = 1 << `FIFO_BITS;

	word_t                 fmem [DEPTH];
	logic [`FIFO_BITS:0]   wr_ptr;     // next write, extra bit for full
	logic [`FIFO_BITS:0]   end_ptr;    // end of the last committed block
	logic [`FIFO_BITS:0]   rd_ptr;     // next word to load into out_data
	logic [`FIFO_BITS:0]   used;
	logic [`WIN_BITS+1:0]  free_words;
	fifo_addr_t            wr_addr;
	fifo_addr_t            rd_addr;
	logic                  load;       // move a committed word to the output register

	assign wr_addr    = wr_ptr[`FIFO_BITS-1:0];
	assign rd_addr    = rd_ptr[`FIFO_BITS-1:0];
	assign used       = wr_ptr - rd_ptr; // output register slot already free
	assign free_words = DEPTH[`WIN_BITS+1:0] - {{(`WIN_BITS-`FIFO_BITS+1){1'b0}}, used};
	assign space_ok   = blk_start && (free_words >= need);
	assign load       = (rd_ptr != end_ptr) && (!out_valid || out_ready);

	//////////////////////////////////////////////////
	// pointers and output handshake
	//////////////////////////////////////////////////

	always_ff @(posedge ADCCLK) begin
		if (rst) begin
			wr_ptr    <= '0;
			end_ptr   <= '0;
			rd_ptr    <= '0;
			out_valid <= 1'b0;
		end else begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;
			if (blk_commit)
				end_ptr <= wr_en ? wr_ptr + 1'b1 : wr_ptr;
			if (load) begin
				rd_ptr    <= rd_ptr + 1'b1;
				out_valid <= 1'b1;
			end else if (out_ready) begin
				out_valid <= 1'b0;   // word taken, nothing committed behind it
			end
		end
	end

	always_ff @(posedge ADCCLK) begin
		if (wr_en)
			fmem[wr_addr] <= wr_word;
		if (load)
			out_data <= fmem[rd_addr]; // holds through a stall
	end

endmodule

// ==== block_writer.sv ====
`include "chan_config.svh"

module block_writer (
	input  logic                  ADCCLK,
	input  logic                  rst,
	input  logic                  trig,        // one cycle self trigger
	input  logic [9:0]            trig_num,
	input  chan_pkg::cb_addr_t    wr_addr,     // buffer write slot at trig
	input  chan_pkg::adc_t        ped_used,
	input  logic [5:0]            chan_num,
	input  logic [`WIN_BITS-1:0]  winlen,      // data words per block
	input  logic [`WIN_BITS-1:0]  swinbeg,     // samples taken before the trigger sample
	output chan_pkg::cb_addr_t    cb_rd_addr,
	input  chan_pkg::sample_t     cb_rd_data,
	output logic                  blk_start,   // space request, size on the fifo need port
	input  logic                  space_ok,
	output logic                  wr_en,
	output chan_pkg::word_t       wr_word,
	output logic                  blk_commit,
	output logic                  missed       // trigger dropped, fifo too full
);
	import chan_pkg::*;

	localparam int PAD_BITS = 16 - `ADC_BITS;

	blk_state_e           state;
	cb_addr_t             trig_addr; // wr_addr one slot past the trigger sample
	logic [9:0]           num_q;     // trigger number of this block
	logic [`WIN_BITS-1:0] blk_len;   // length field of the control word
	logic [`WIN_BITS-1:0] to_copy;   // data words left
	logic                 blk_par;   // toggles per committed block

	// a trigger is only taken when idle, zero window writes nothing
	assign blk_start = trig && (state == ST_IDLE) && (winlen != '0);

	//////////////////////////////////////////////////
	// block sequence
	//////////////////////////////////////////////////

	always_ff @(posedge ADCCLK) begin
		if (rst) begin
			state   <= ST_IDLE;
			missed  <= 1'b0;
			blk_par <= 1'b0;
		end else begin
			missed <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (blk_start) begin
						if (space_ok)
							state <= ST_HEAD;
						else
							missed <= 1'b1; // nothing written for this one
					end
				end
				ST_HEAD: state <= ST_NUM;
				ST_NUM:  state <= ST_PED;
				ST_PED:  state <= ST_COPY;
				ST_COPY: begin
					if (to_copy == 1)
						state <= ST_COMMIT;
				end
				ST_COMMIT: begin
					blk_par <= ~blk_par;
					state   <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// trigger context and buffer read address
	always_ff @(posedge ADCCLK) begin
		if (blk_start) begin
			trig_addr <= wr_addr;
			num_q     <= trig_num;
			blk_len   <= winlen + 2'd2;   // counts number and pedestal words
			to_copy   <= winlen;
		end
		if (state == ST_COPY)
			to_copy <= to_copy - 1'b1;
		// first read issued in ST_PED so data lines up with ST_COPY
		if (state == ST_NUM)
			cb_rd_addr <= trig_addr - swinbeg[`CB_BITS-1:0] - 1'b1;
		else if ((state == ST_PED) || (state == ST_COPY))
			cb_rd_addr <= cb_rd_addr + 1'b1;
	end

	//////////////////////////////////////////////////
	// fifo word per state
	//////////////////////////////////////////////////

	always_comb begin
		wr_en = 1'b1;
		case (state)
			ST_HEAD: wr_word = {1'b1, chan_num, blk_len};           // control word
			ST_NUM:  wr_word = {4'h0, blk_par, 1'b0, num_q};        // self trigger type 0
			ST_PED:  wr_word = {{PAD_BITS{1'b0}}, ped_used};
			ST_COPY: wr_word = {1'b0, cb_rd_data[14:0]};            // msb clear on data
			default: begin
				wr_en   = 1'b0;
				wr_word = '0;
			end
		endcase
	end

	assign blk_commit = (state == ST_COMMIT);

endmodule

// ==== chan_config.svh ====
`ifndef CHAN_CONFIG_SVH
`define CHAN_CONFIG_SVH

//////////////////////////////////////////////////
// channel widths and constants
//////////////////////////////////////////////////

`define ADC_BITS      12  // adc sample width
`define CB_BITS       8   // prehistory buffer, 256 samples
`define FIFO_BITS     9   // output fifo, 512 words

// pedestal averaging
`define PED_CNT_BITS  4   // 16 accepted samples per period
`define PED_RANGE     5   // small signal band in pedmode 1

// window length and window offset
`define WIN_BITS      9

`endif

// ==== chan_pedestal.sv ====
`include "chan_config.svh"

module chan_pedestal (
	input  logic              ADCCLK,
	input  logic              rst,
	input  chan_pkg::adc_t    adc_data,  // raw adc code
	input  logic              invert,    // flip waveform sign
	input  logic              pedmode,   // 0 full update, 1 small signal and step by 1
	input  logic              pedinh,    // freeze the pedestal in use
	output chan_pkg::sample_t sample,    // pedestal subtracted, one cycle after adc_data
	output chan_pkg::adc_t    ped,       // running average
	output chan_pkg::adc_t    ped_used   // value actually subtracted
);
	import chan_pkg::*;

	localparam int SUM_BITS = `ADC_BITS + `PED_CNT_BITS;
	localparam int PAD_BITS = 16 - `ADC_BITS;

	logic [`PED_CNT_BITS-1:0] ped_cnt;     // accepted samples in this period
	logic [SUM_BITS-1:0]      ped_sum;     // sum so far
	logic [SUM_BITS-1:0]      sum_next;    // sum including current sample
	adc_t                     ped_avg;     // average of a full period
	logic signed [`ADC_BITS:0] ped_diff;   // adc_data - ped
	logic                     in_range;
	logic                     accept;      // sample counts toward the average

	assign sum_next = ped_sum + {{`PED_CNT_BITS{1'b0}}, adc_data};
	assign ped_avg  = sum_next[SUM_BITS-1:`PED_CNT_BITS]; // divide by 16
	assign ped_diff = $signed({1'b0, adc_data}) - $signed({1'b0, ped});
	assign in_range = (ped_diff <= `PED_RANGE) && (ped_diff >= -`PED_RANGE);
	assign accept   = ~pedmode | in_range; // mode 0 takes everything

	always_ff @(posedge ADCCLK) begin
		if (rst) begin
			ped_cnt  <= '0;
			ped_sum  <= '0;
			ped      <= '0;
			ped_used <= '0;
		end else if (accept) begin
			if ((ped_cnt == '0) && !pedinh)
				ped_used <= ped;              // period start, take latest average
			if (&ped_cnt) begin
				ped_sum <= '0;                // next period starts empty
				if (!pedmode)
					ped <= ped_avg;
				else if (ped_avg > ped)
					ped <= ped + 1'b1;        // creep up
				else if (ped_avg < ped)
					ped <= ped - 1'b1;        // creep down
			end else begin
				ped_sum <= sum_next;
			end
			ped_cnt <= ped_cnt + 1'b1;        // wraps at period end
		end
	end

	// subtraction, with optional sign flip
	always_ff @(posedge ADCCLK) begin
		if (invert)
			sample <= {{PAD_BITS{1'b0}}, ped_used} - {{PAD_BITS{1'b0}}, adc_data};
		else
			sample <= {{PAD_BITS{1'b0}}, adc_data} - {{PAD_BITS{1'b0}}, ped_used};
	end

endmodule

// ==== chan_pkg.sv ====
`include "chan_config.svh"

package chan_pkg;

	typedef logic [`ADC_BITS-1:0] adc_t;        // raw adc code
	typedef logic signed [15:0] sample_t;       // adc minus pedestal, signed
	typedef logic [`CB_BITS-1:0] cb_addr_t;     // prehistory buffer address
	typedef logic [`FIFO_BITS-1:0] fifo_addr_t; // output fifo address
	typedef logic [15:0] word_t;                // one output fifo word

	// block writer states, one fifo word per state except idle and commit
	typedef enum logic [2:0] {
		ST_IDLE,   // wait for trigger
		ST_HEAD,   // control word
		ST_NUM,    // self trigger number word
		ST_PED,    // pedestal word
		ST_COPY,   // window samples from the prehistory buffer
		ST_COMMIT  // publish block to the read side
	} blk_state_e;

endpackage

// ==== chan_proc.sv ====
`include "chan_config.svh"

module chan_proc (
	input  logic                  ADCCLK,
	input  logic                  rst,
	input  chan_pkg::adc_t        adc_data,
	input  logic [5:0]            chan_num,
	input  chan_pkg::adc_t        sthr,
	input  logic [15:0]           prescale,
	input  logic [`WIN_BITS-1:0]  swinbeg,
	input  logic [`WIN_BITS-1:0]  winlen,
	input  logic                  invert,
	input  logic                  pedmode,
	input  logic                  pedinh,
	input  logic                  inhibit,
	output chan_pkg::adc_t        ped,
	output chan_pkg::word_t       out_data,
	output logic                  out_valid,
	input  logic                  out_ready,
	output logic                  missed
);
	import chan_pkg::*;

	sample_t    sample;      // pedestal subtracted stream
	adc_t       ped_used;
	logic       trig;
	logic [9:0] trig_num;
	cb_addr_t   wr_addr;
	cb_addr_t   cb_rd_addr;
	sample_t    cb_rd_data;
	logic       blk_start;
	logic       space_ok;
	logic       wr_en;
	word_t      wr_word;
	logic       blk_commit;

	chan_pedestal u_ped (
		.ADCCLK(ADCCLK), .rst(rst), .adc_data(adc_data), .invert(invert),
		.pedmode(pedmode), .pedinh(pedinh), .sample(sample), .ped(ped),
		.ped_used(ped_used)
	);

	self_trigger u_trig (
		.ADCCLK(ADCCLK), .rst(rst), .sample(sample), .sthr(sthr),
		.prescale(prescale), .inhibit(inhibit), .trig(trig), .trig_num(trig_num)
	);

	prehistory_buffer u_buf (
		.ADCCLK(ADCCLK), .sample(sample), .wr_addr(wr_addr),
		.cb_rd_addr(cb_rd_addr), .cb_rd_data(cb_rd_data)
	);

	block_writer u_writer (
		.ADCCLK(ADCCLK), .rst(rst), .trig(trig), .trig_num(trig_num),
		.wr_addr(wr_addr), .ped_used(ped_used), .chan_num(chan_num),
		.winlen(winlen), .swinbeg(swinbeg), .cb_rd_addr(cb_rd_addr),
		.cb_rd_data(cb_rd_data), .blk_start(blk_start), .space_ok(space_ok),
		.wr_en(wr_en), .wr_word(wr_word), .blk_commit(blk_commit), .missed(missed)
	);

	// block size is the window plus control, number and pedestal words
	block_fifo u_fifo (
		.ADCCLK(ADCCLK), .rst(rst), .blk_start(blk_start),
		.need({2'b00, winlen} + 11'd3), .space_ok(space_ok), .wr_en(wr_en),
		.wr_word(wr_word), .blk_commit(blk_commit), .out_data(out_data),
		.out_valid(out_valid), .out_ready(out_ready)
	);

endmodule

// ==== chan_proc_assert.sv ====
module chan_proc_assert (
	input logic            ADCCLK,
	input logic            rst,
	input logic            blk_start,
	input logic            space_ok,
	input logic            wr_en,
	input logic            blk_commit,
	input chan_pkg::word_t out_data,
	input logic            out_valid,
	input logic            out_ready
);

	logic blk_open; // granted block not yet committed

	always_ff @(posedge ADCCLK) begin
		if (rst)
			blk_open <= 1'b0;
		else if (blk_start && space_ok)
			blk_open <= 1'b1;   // writer owns the fifo from the grant on
		else if (blk_commit)
			blk_open <= 1'b0;   // block published, writer back to idle
	end

	//////////////////////////////////////////////////
	// output port and writer protocol
	//////////////////////////////////////////////////

	// stalled word stays put until taken
	a_stall_hold: assert property (@(posedge ADCCLK) disable iff (rst)
		(out_valid && !out_ready) |=> (out_valid && $stable(out_data)))
		else $error("output word changed or dropped during a stall");

	a_reset_valid: assert property (@(posedge ADCCLK) rst |=> !out_valid)
		else $error("out_valid high in reset");

	// no new request until the open block is committed
	a_start_idle: assert property (@(posedge ADCCLK) disable iff (rst)
		blk_start |-> !blk_open)
		else $error("blk_start while the writer is busy");

	// words and commit only inside a granted block
	a_write_open: assert property (@(posedge ADCCLK) disable iff (rst)
		(wr_en || blk_commit) |-> blk_open)
		else $error("fifo write or commit outside a granted block");

endmodule

bind block_fifo chan_proc_assert u_assert (
	.ADCCLK(ADCCLK),
	.rst(rst),
	.blk_start(blk_start),
	.space_ok(space_ok),
	.wr_en(wr_en),
	.blk_commit(blk_commit),
	.out_data(out_data),
	.out_valid(out_valid),
	.out_ready(out_ready)
);

// ==== chan_proc_tb.sv ====
`include "chan_config.svh"

module chan_proc_tb;
	import chan_pkg::*;

	logic                 ADCCLK = 1'b0;
	logic                 rst;
	adc_t                 adc_data;
	logic [5:0]           chan_num;
	adc_t                 sthr;
	logic [15:0]          prescale;
	logic [`WIN_BITS-1:0] swinbeg;
	logic [`WIN_BITS-1:0] winlen;
	logic                 invert;
	logic                 pedmode;
	logic                 pedinh;
	logic                 inhibit;
	adc_t                 ped;
	word_t                out_data;
	logic                 out_valid;
	logic                 out_ready;
	logic                 missed;

	int          seed = 45;
	int          errors = 0;
	int          tests = 0;
	int          cyc = 0;          // adc samples driven so far
	adc_t        base;             // flat baseline between pulses
	adc_t        hist [16384];     // driven adc codes by sample index
	word_t       exp_q [$];        // predicted fifo words
	word_t       rx_q [$];         // words taken from the output port
	int          exp_total = 0;
	int          rx_total = 0;
	int          exp_missed = 0;
	int          missed_cnt = 0;
	logic        rnd_ready = 1'b0; // random out_ready per cycle
	logic [15:0] pcnt = '0;        // model prescale count
	logic [9:0]  tnum = '0;        // model trigger number
	logic        par = 1'b0;       // model block parity

	chan_proc u_dut (.*);

	always #20 ADCCLK = ~ADCCLK;

	// output port and missed monitor
	always @(posedge ADCCLK) begin
		if (!rst && out_valid && out_ready) begin
			rx_q.push_back(out_data);
			rx_total++;
		end
		if (!rst && missed)
			missed_cnt++;
	end

	//////////////////////////////////////////////////
	// stimulus helpers
	//////////////////////////////////////////////////

	function automatic int rnd(input int span);
		int r;
		r = $random(seed) & 32'h7fffffff;
		return r % span;
	endfunction

	// one adc sample, driven just after the rising edge
	task automatic step(input adc_t a);
		int rv;
		@(posedge ADCCLK);
		#2;
		adc_data = a;
		hist[cyc % 16384] = a;
		cyc++;
		if (rnd_ready) begin
			rv = $random(seed);
			out_ready = rv[0];
		end
	endtask

	task automatic idle(input int n);
		repeat (n) step(base);
	endtask

	// predicted words of one block, window taken from the driven history
	task automatic expect_block(input int tidx);
		word_t d;
		exp_q.push_back({1'b1, chan_num, winlen + 9'd2});
		exp_q.push_back({4'h0, par, 1'b0, tnum});
		exp_q.push_back({4'h0, base});
		for (int j = 0; j < int'(winlen); j++) begin
			if (invert)
				d = {4'h0, base} - {4'h0, hist[(tidx - int'(swinbeg) + j) % 16384]};
			else
				d = {4'h0, hist[(tidx - int'(swinbeg) + j) % 16384]} - {4'h0, base};
			exp_q.push_back({1'b0, d[14:0]}); // msb clear on data words
		end
		exp_total += int'(winlen) + 3;
		par = ~par;
	endtask

	// one crossing pulse, then baseline until the block is written
	task automatic pulse(input logic inh);
		int   len;
		int   tidx;
		int   held;
		logic fire;
		adc_t h;
		len  = 2 + rnd(4);
		tidx = cyc;                    // first sample over threshold
		held = exp_total - rx_total;   // words still inside the fifo
		if (held > 0)
			held--;                    // one of them sits in the output register
		fire    = 1'b0;
		inhibit = inh;
		for (int i = 0; i < len; i++) begin
			h = 12'(301 + rnd(512));   // always above sthr
			step(invert ? base - h : base + h);
		end
		idle(3);
		inhibit = 1'b0;
		if (!inh) begin
			if (pcnt == 0) begin
				fire = 1'b1;
				pcnt = prescale;
				tnum++;
			end else begin
				pcnt--;
			end
		end
		idle(24);                      // window and block complete
		if (fire && winlen != 0) begin
			if (512 - held >= int'(winlen) + 3)
				expect_block(tidx);
			else
				exp_missed++;          // not enough room
		end
	endtask

	//////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////

	task automatic drain(input string name);
		int    n;
		word_t exp_w;
		word_t act_w;
		n = 0;
		while (rx_total < exp_total && n < 4000) begin
			step(base);
			n++;
		end
		if (rx_total < exp_total) begin
			$display("%s: timeout, only %0d of %0d words arrived", name, rx_total, exp_total);
			errors++;
		end
		idle(4); // nothing may trail the last block
		if (rx_q.size() != exp_q.size()) begin
			$display("MISMATCH %s: word count expected %0d actual %0d",
				name, exp_q.size(), rx_q.size());
			errors++;
		end
		while (exp_q.size() > 0 && rx_q.size() > 0) begin
			exp_w = exp_q.pop_front();
			act_w = rx_q.pop_front();
			if (exp_w != act_w) begin
				$display("MISMATCH %s: expected %h actual %h", name, exp_w, act_w);
				errors++;
			end
		end
		exp_q.delete();
		rx_q.delete();
	endtask

	task automatic end_test(input string name, input int e0);
		if (missed_cnt != exp_missed) begin
			$display("MISMATCH %s: missed pulses expected %0d actual %0d",
				name, exp_missed, missed_cnt);
			errors++;
			exp_missed = missed_cnt;   // resync for later tests
		end
		tests++;
		if (errors == e0)
			$display("test %s: ok", name);
		else
			$display("test %s: %0d errors", name, errors - e0);
	endtask

	//////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////

	initial begin
		int   e0;
		int   d;
		int   n;
		int   m0;
		adc_t prev;
		rst       = 1'b1;
		base      = 12'(1200 + rnd(512));
		adc_data  = base;
		chan_num  = 6'(rnd(64));
		sthr      = 12'd300;
		prescale  = '0;
		swinbeg   = '0;
		winlen    = '0;
		invert    = 1'b0;
		pedmode   = 1'b0;
		pedinh    = 1'b0;
		inhibit   = 1'b1;  // quiet until ped_used matches the baseline
		out_ready = 1'b1;
		repeat (4) step(base);
		rst = 1'b0;

		e0 = errors;
		if (out_valid !== 1'b0 || missed !== 1'b0) begin
			$display("reset: out_valid or missed not low after reset");
			errors++;
		end
		if (ped !== 12'd0) begin
			$display("MISMATCH reset: ped expected 0 actual %0d", ped);
			errors++;
		end
		end_test("reset", e0);

		// full update, then small signal stepping toward a nearby baseline
		e0 = errors;
		n = 0;
		while (ped != base && n < 40) begin
			step(base);
			n++;
		end
		if (ped != base) begin
			$display("MISMATCH pedestal: expected %0d actual %0d", base, ped);
			errors++;
		end
		d = 1 + rnd(`PED_RANGE);
		if (rnd(2) == 1)
			d = -d;
		base    = 12'(int'(base) + d);
		pedmode = 1'b1;
		prev    = ped;
		n = 0;
		while (ped != base && n < 16 * (`PED_RANGE + 3)) begin
			step(base);
			n++;
			if (ped != prev && (ped > prev ? ped - prev : prev - ped) != 12'd1) begin
				$display("pedestal: ped jumped from %0d to %0d instead of one step", prev, ped);
				errors++;
			end
			prev = ped;
		end
		if (ped != base) begin
			$display("MISMATCH pedestal step: expected %0d actual %0d", base, ped);
			errors++;
		end
		idle(40);      // ped_used takes the new value at a period start
		pedinh  = 1'b1;
		inhibit = 1'b0;
		end_test("pedestal", e0);

		e0 = errors;
		repeat (6) begin
			winlen  = 9'(4 + rnd(17));
			swinbeg = 9'(rnd(9));
			pulse(1'b0);
		end
		drain("blocks");
		end_test("blocks", e0);

		e0 = errors;
		invert = 1'b1; // pulses go below the baseline
		repeat (6) begin
			winlen  = 9'(4 + rnd(17));
			swinbeg = 9'(rnd(9));
			pulse(1'b0);
		end
		drain("invert");
		end_test("invert", e0);

		e0 = errors;
		invert   = 1'b0;
		prescale = 16'(1 + rnd(3));
		repeat (14) pulse(rnd(4) == 0);  // some pulses under inhibit
		prescale = '0;
		drain("prescale");
		end_test("prescale", e0);

		// fill the fifo with out_ready low until a trigger is missed
		e0 = errors;
		winlen    = 9'd20;
		swinbeg   = 9'(rnd(9));
		out_ready = 1'b0;
		m0 = exp_missed;
		n = 0;
		while (exp_missed == m0 && n < 60) begin
			pulse(1'b0);
			n++;
		end
		if (exp_missed == m0) begin
			$display("backpressure: fifo never ran out of room after %0d triggers", n);
			errors++;
		end
		rnd_ready = 1'b1;
		drain("backpressure");
		end_test("backpressure", e0);

		$display("tests %0d, errors %0d", tests, errors);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

// ==== list.f ====
+incdir+.
chan_pkg.sv
chan_pedestal.sv
self_trigger.sv
prehistory_buffer.sv
block_writer.sv
block_fifo.sv
chan_proc.sv
chan_proc_assert.sv
chan_proc_tb.sv

// ==== prehistory_buffer.sv ====
`include "chan_config.svh"

module prehistory_buffer (
	input  logic               ADCCLK,
	input  chan_pkg::sample_t  sample,      // written every cycle
	output chan_pkg::cb_addr_t wr_addr,     // slot taking the current sample
	input  chan_pkg::cb_addr_t cb_rd_addr,
	output chan_pkg::sample_t  cb_rd_data   // one cycle after cb_rd_addr
);
	import chan_pkg::*;

	sample_t  cbuf [2**`CB_BITS];  // circular sample memory
	cb_addr_t wr_ptr = '0;         // free running, wraps every 256 samples

	assign wr_addr = wr_ptr;

	always_ff @(posedge ADCCLK) begin
		cbuf[wr_ptr] <= sample;
		wr_ptr       <= wr_ptr + 1'b1;
	end

	// registered read port
	always_ff @(posedge ADCCLK) begin
		cb_rd_data <= cbuf[cb_rd_addr];
	end

endmodule

// ==== self_trigger.sv ====
`include "chan_config.svh"

module self_trigger (
	input  logic              ADCCLK,
	input  logic              rst,
	input  chan_pkg::sample_t sample,    // pedestal subtracted sample
	input  chan_pkg::adc_t    sthr,      // trigger threshold
	input  logic [15:0]       prescale,  // crossings skipped between triggers
	input  logic              inhibit,   // no self triggers while high
	output logic              trig,      // one cycle pulse
	output logic [9:0]        trig_num   // triggers after prescale, wraps
);

	logic        armed;      // above threshold, waits for the half level
	logic        above;      // sample over sthr
	logic        below_half; // sample at or under sthr/2
	logic [15:0] presc_cnt;  // crossings left before next trigger

	assign above      = sample > $signed({1'b0, sthr});
	assign below_half = sample <= $signed({2'b00, sthr[`ADC_BITS-1:1]}); // hysteresis

	//////////////////////////////////////////////////
	// discriminator and prescale
	//////////////////////////////////////////////////

	always_ff @(posedge ADCCLK) begin
		if (rst) begin
			armed     <= 1'b0;
			presc_cnt <= '0;
			trig      <= 1'b0;
			trig_num  <= '0;
		end else begin
			trig <= 1'b0; // pulse only
			if (inhibit) begin
				armed <= 1'b0;                        // held off, crossings ignored
			end else if (above && !armed) begin
				armed <= 1'b1;                        // new crossing
				if (presc_cnt != '0) begin
					presc_cnt <= presc_cnt - 1'b1;
				end else begin
					presc_cnt <= prescale;            // reload
					trig      <= 1'b1;
					trig_num  <= trig_num + 1'b1;     // counted on fire, first block is 1
				end
			end else if (below_half) begin
				armed <= 1'b0;                        // back near baseline, rearm
			end
		end
	end

endmodule
